// ==== logic/nabp_pkg.sv ====
package nabp_pkg;

    // projection angle in whole degrees, 0 to 179
    typedef logic [7:0] angle_t;

    // scan decode boundaries
    localparam angle_t ANGLE_45  = 8'd45;
    localparam angle_t ANGLE_90  = 8'd90;
    localparam angle_t ANGLE_135 = 8'd135;

    typedef logic signed [15:0] sample_t;

    // index into a filtered line
    typedef logic [5:0] addr_t;

    // taps per window carried to the processing elements
    localparam int PE_TAPS = 4;

    typedef enum logic {
        scan_x,
        scan_y
    } scan_mode_t;

    typedef enum logic {
        scan_forward,
        scan_reverse
    } scan_dir_t;

    typedef enum logic [3:0] {
        ready_s,
        setup_1_s,
        setup_2_s,
        setup_3_s,
        fill_s,
        fill_and_shift_setup_1_s,
        fill_and_shift_setup_2_s,
        fill_and_shift_setup_3_s,
        fill_and_shift_s,
        shift_s
    } swap_state_t;

    // one side of the filtered RAM
    typedef struct packed {
        angle_t angle;
        logic   valid;
    } fr_angle_t;

    typedef struct packed {
        logic                    pe_kick;
        scan_mode_t              pe_scan_mode;
        scan_dir_t               pe_scan_direction;
        sample_t [PE_TAPS-1:0]   taps;
    } pe_out_t;

endpackage

// ==== logic/shifter_lut.sv ====
`timescale 1ns/1ps

module shifter_lut
    import nabp_pkg::*;
(
    input  logic   clk,
    input  angle_t angle,
    output addr_t  accu_base
);

    localparam int BASE_STEP = 4;

    // angle folded into one 45 degree octant
    angle_t folded;

    // start address within the filtered line
    addr_t base;

    always_comb
    begin
        folded = angle % ANGLE_45;
        base   = addr_t'(folded / BASE_STEP);
    end

    // registered table output, one cycle behind the angle
    always_ff @(posedge clk)
    begin
        accu_base <= base;
    end

endmodule

// ==== logic/mapper_lut.sv ====
`timescale 1ns/1ps

module mapper_lut
    import nabp_pkg::*;
(
    input  logic   clk,
    input  angle_t angle,
    output addr_t  stride
);

    // window stride per scan mode
    localparam addr_t STRIDE_X = 6'd1;
    localparam addr_t STRIDE_Y = 6'd2;

    scan_mode_t mode;

    // same boundaries as the scan decode, but for the filling side
    always_comb
    begin
        if (angle < ANGLE_45 || angle >= ANGLE_135)
            mode = scan_x;
        else
            mode = scan_y;
    end

    always_ff @(posedge clk)
    begin
        case (mode)
            scan_x:
                stride <= STRIDE_X;
            default:
                stride <= STRIDE_Y;
        endcase
    end

endmodule

// ==== logic/processing_swappable.sv ====
`timescale 1ns/1ps

module processing_swappable
    import nabp_pkg::*;
#(
    parameter int LINE_LEN   = 32,
    parameter int PARTITIONS = 4
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    fill_kick,
    input  logic                    shift_kick,
    input  addr_t                   accu_base,
    input  addr_t                   stride,
    input  sample_t                 fr_val,
    output addr_t                   s_val,
    output logic                    fill_done,
    output logic                    shift_done,
    output logic                    pe_kick,
    output sample_t [PARTITIONS-1:0] taps
);

    localparam int CNT_W = $clog2(LINE_LEN);

    // line buffer, written by the fill and read by the shift
    sample_t line_q [LINE_LEN];

    logic             filling;
    logic [CNT_W-1:0] fill_cnt;
    addr_t            fill_addr;

    logic             shifting;
    addr_t            win_start;
    addr_t            line_stride;

    // fill sequencer
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            filling   <= 1'b0;
            fill_done <= 1'b0;
            fill_cnt  <= '0;
            fill_addr <= '0;
        end
        else if (fill_kick)
        begin
            filling   <= 1'b1;
            fill_done <= 1'b0;
            fill_cnt  <= '0;
            fill_addr <= accu_base;
        end
        else if (filling)
        begin
            fill_cnt  <= fill_cnt + 1'b1;
            fill_addr <= fill_addr + 1'b1;
            if (fill_cnt == CNT_W'(LINE_LEN - 1))
            begin
                filling   <= 1'b0;
                fill_done <= 1'b1;
            end
        end
    end

    // RAM returns the sample in the same cycle
    always_ff @(posedge clk)
    begin
        if (filling)
        begin
            line_q[fill_cnt] <= fr_val;
        end
    end

    // stride comes from the table while it still shows the filled angle
    always_ff @(posedge clk)
    begin
        if (fill_kick)
        begin
            line_stride <= stride;
        end
    end

    // shift sequencer, one window per cycle
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            shifting   <= 1'b0;
            shift_done <= 1'b0;
            win_start  <= '0;
        end
        else if (shift_kick)
        begin
            shifting   <= 1'b1;
            shift_done <= 1'b0;
            win_start  <= '0;
        end
        else if (shifting)
        begin
            // stop on the last window that still fits the line
            if (int'(win_start) + int'(line_stride) + PARTITIONS > LINE_LEN)
            begin
                shifting   <= 1'b0;
                shift_done <= 1'b1;
            end
            else
            begin
                win_start <= win_start + line_stride;
            end
        end
    end

    assign s_val   = fill_addr;
    assign pe_kick = shifting;

    // tap window at the current start
    always_comb
    begin
        for (int i = 0; i < PARTITIONS; i++)
        begin
            taps[i] = line_q[int'(win_start) + i];
        end
    end

endmodule

// ==== logic/processing_swap_control.sv ====
`timescale 1ns/1ps

module processing_swap_control
    import nabp_pkg::*;
#(
    parameter int LINE_LEN   = 32,
    parameter int PARTITIONS = PE_TAPS
)
(
    input  logic      clk,
    input  logic      reset_n,
    input  fr_angle_t fr0,
    input  fr_angle_t fr1,
    input  logic      fr_next_angle_ack,
    input  sample_t   fr0_val,
    input  sample_t   fr1_val,
    output addr_t     fr0_s_val,
    output addr_t     fr1_s_val,
    output logic      fr_next_angle,
    output logic      fr_done,
    output pe_out_t   pe
);

    swap_state_t state;
    swap_state_t next_state;

    // sel = 0 means swappable 0 fills and swappable 1 shifts
    logic sel;
    logic swap;

    logic fill_kick;
    logic shift_kick;
    logic fill_done;
    logic shift_done;

    logic sw0_fill_kick;
    logic sw1_fill_kick;
    logic sw0_shift_kick;
    logic sw1_shift_kick;
    logic sw0_fill_done;
    logic sw1_fill_done;
    logic sw0_shift_done;
    logic sw1_shift_done;
    logic sw0_pe_kick;
    logic sw1_pe_kick;

    addr_t   sw0_s_val;
    addr_t   sw1_s_val;
    sample_t sw0_fr_val;
    sample_t sw1_fr_val;
    sample_t [PARTITIONS-1:0] sw0_taps;
    sample_t [PARTITIONS-1:0] sw1_taps;

    addr_t accu_base;
    addr_t stride;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= ready_s;
            sel   <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (swap)
                sel <= ~sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (fr_next_angle_ack)
                    next_state = setup_1_s;
            setup_1_s:
                next_state = setup_2_s;
            setup_2_s:
                next_state = setup_3_s;
            setup_3_s:
                next_state = fill_s;
            fill_s:
                if (fr_next_angle_ack)
                    next_state = fill_and_shift_setup_1_s;
            fill_and_shift_setup_1_s:
                next_state = fill_and_shift_setup_2_s;
            fill_and_shift_setup_2_s:
                next_state = fill_and_shift_setup_3_s;
            fill_and_shift_setup_3_s:
                if (fr0.valid)
                    next_state = fill_and_shift_s;
                else
                    next_state = shift_s;
            fill_and_shift_s:
                if (fr_next_angle_ack)
                    next_state = fill_and_shift_setup_1_s;
            shift_s:
                if (shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // last setup cycle swaps roles and kicks both sides
    assign swap       = (state == setup_3_s) || (state == fill_and_shift_setup_3_s);
    assign fill_kick  = swap && fr0.valid;
    assign shift_kick = swap && fr1.valid;

    // kicks follow the roles after the toggle
    assign sw0_fill_kick  = fill_kick && sel;
    assign sw1_fill_kick  = fill_kick && !sel;
    assign sw0_shift_kick = shift_kick && !sel;
    assign sw1_shift_kick = shift_kick && sel;

    assign fill_done  = sel ? sw1_fill_done : sw0_fill_done;
    assign shift_done = sel ? sw0_shift_done : sw1_shift_done;

    // RAM address and data crossing
    assign fr0_s_val  = sel ? sw1_s_val : sw0_s_val;
    assign fr1_s_val  = sel ? sw0_s_val : sw1_s_val;
    assign sw0_fr_val = sel ? fr1_val : fr0_val;
    assign sw1_fr_val = sel ? fr0_val : fr1_val;

    assign fr_done = (state != ready_s) && (next_state == ready_s);

    always_comb
    begin
        fr_next_angle = 1'b0;
        case (state)
            ready_s:
                fr_next_angle = 1'b1;
            fill_s:
                fr_next_angle = fill_done;
            fill_and_shift_s:
                fr_next_angle = fill_done && shift_done;
            default:
                fr_next_angle = 1'b0;
        endcase
    end

    // outputs to the processing elements, scan decode from the shifted angle
    always_comb
    begin
        pe.pe_kick = sel ? sw0_pe_kick : sw1_pe_kick;
        pe.taps    = sel ? sw0_taps : sw1_taps;
        if (fr1.angle < ANGLE_45 || fr1.angle >= ANGLE_135)
            pe.pe_scan_mode = scan_x;
        else
            pe.pe_scan_mode = scan_y;
        if (fr1.angle < ANGLE_90)
            pe.pe_scan_direction = scan_forward;
        else
            pe.pe_scan_direction = scan_reverse;
    end

    processing_swappable #(
        .LINE_LEN   (LINE_LEN),
        .PARTITIONS (PARTITIONS)
    ) sw0_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (sw0_fill_kick),
        .shift_kick (sw0_shift_kick),
        .accu_base  (accu_base),
        .stride     (stride),
        .fr_val     (sw0_fr_val),
        .s_val      (sw0_s_val),
        .fill_done  (sw0_fill_done),
        .shift_done (sw0_shift_done),
        .pe_kick    (sw0_pe_kick),
        .taps       (sw0_taps)
    );

    processing_swappable #(
        .LINE_LEN   (LINE_LEN),
        .PARTITIONS (PARTITIONS)
    ) sw1_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (sw1_fill_kick),
        .shift_kick (sw1_shift_kick),
        .accu_base  (accu_base),
        .stride     (stride),
        .fr_val     (sw1_fr_val),
        .s_val      (sw1_s_val),
        .fill_done  (sw1_fill_done),
        .shift_done (sw1_shift_done),
        .pe_kick    (sw1_pe_kick),
        .taps       (sw1_taps)
    );

    // both tables follow the angle waiting to be filled
    shifter_lut shifter_lut_inst (
        .clk       (clk),
        .angle     (fr0.angle),
        .accu_base (accu_base)
    );

    mapper_lut mapper_lut_inst (
        .clk    (clk),
        .angle  (fr0.angle),
        .stride (stride)
    );

endmodule

// ==== bench/tb_processing.sv ====
`timescale 1ns/1ps

module tb_processing
    import nabp_pkg::*;
();

    localparam int LINE_LEN        = 32;
    localparam int PARTITIONS      = PE_TAPS;
    localparam int NUM_FIXED       = 4;
    localparam int NUM_RANDOM      = 6;
    localparam int NUM_ANGLES      = NUM_FIXED + NUM_RANDOM;
    localparam int RESET_CYCLES    = 16;
    localparam int FILL_LAG        = 3;
    localparam int WATCHDOG_CYCLES = (NUM_ANGLES + 2) * 4 * LINE_LEN;

    logic      clk;
    logic      reset_n;
    fr_angle_t fr0;
    fr_angle_t fr1;
    logic      fr_next_angle_ack;
    sample_t   fr0_val;
    sample_t   fr1_val;
    addr_t     fr0_s_val;
    addr_t     fr1_s_val;
    logic      fr_next_angle;
    logic      fr_done;
    pe_out_t   pe;

    angle_t      angle_list [NUM_ANGLES];
    logic [15:0] lfsr;
    logic        first_cycle;
    int          err_count [1:6];

    // scoreboard state updated on the rising edge
    int    ack_count;
    logic  fill_active;
    int    fill_phase;
    addr_t fill_base;
    int    shift_num;
    int    win_idx;
    logic  prev_kick;
    logic  prev_done;
    int    done_count;

    angle_t                  cur_angle;
    int                      tap_pos;
    int                      shifts_complete;
    addr_t                   exp_fill_addr;
    sample_t [PE_TAPS-1:0]   exp_taps;

    processing_swap_control #(
        .LINE_LEN   (LINE_LEN),
        .PARTITIONS (PARTITIONS)
    ) processing_swap_control_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr0               (fr0),
        .fr1               (fr1),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr0_val           (fr0_val),
        .fr1_val           (fr1_val),
        .fr0_s_val         (fr0_s_val),
        .fr1_s_val         (fr1_s_val),
        .fr_next_angle     (fr_next_angle),
        .fr_done           (fr_done),
        .pe                (pe)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // filtered RAM returns a * 3 + g for address a of angle g
    assign fr0_val = sample_t'(int'(fr0_s_val) * 3 + int'(fr0.angle));
    assign fr1_val = sample_t'(int'(fr1_s_val) * 3 + int'(fr1.angle));

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        else
            return state >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int base_for(input angle_t g);
        return (int'(g) % 45) / 4;
    endfunction

    function automatic int stride_for(input angle_t g);
        return (g < 8'd45 || g >= 8'd135) ? 1 : 2;
    endfunction

    // windows whose start plus taps stays within the line
    function automatic int windows_for(input angle_t g);
        return (LINE_LEN - PARTITIONS) / stride_for(g) + 1;
    endfunction

    function automatic scan_mode_t mode_for(input angle_t g);
        return (g < 8'd45 || g >= 8'd135) ? scan_x : scan_y;
    endfunction

    function automatic scan_dir_t dir_for(input angle_t g);
        return (g < 8'd90) ? scan_forward : scan_reverse;
    endfunction

    task automatic value_error(input int test_num, input string name,
                               input logic [63:0] expected, input logic [63:0] actual);
        $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        err_count[test_num]++;
    endtask

    task automatic event_error(input int test_num, input string what);
        $display("error at %0t: %s", $time, what);
        err_count[test_num]++;
    endtask

    task automatic report_test(input int test_num, input string name);
        if (err_count[test_num] == 0)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, err_count[test_num]);
    endtask

    task automatic build_angle_list();
        int value;
        angle_list[0] = 8'd10;
        angle_list[1] = 8'd50;
        angle_list[2] = 8'd100;
        angle_list[3] = 8'd170;
        for (int i = NUM_FIXED; i < NUM_ANGLES; i++)
        begin
            take_bits(8, value);
            while (value >= 180)
                take_bits(8, value);
            angle_list[i] = angle_t'(value);
        end
    endtask

    // one ack per request and one more to move the last angle to side 1
    task automatic serve_requests();
        int served;
        int extra;
        served = 0;
        while (served <= NUM_ANGLES)
        begin
            @(negedge clk);
            if (fr_next_angle)
            begin
                take_bits(2, extra);
                repeat (1 + extra) @(negedge clk);
                fr_next_angle_ack = 1'b1;
                fr1 = fr0;
                fr0.valid = (served < NUM_ANGLES);
                fr0.angle = (served < NUM_ANGLES) ? angle_list[served] : 8'd0;
                served++;
                @(negedge clk);
                fr_next_angle_ack = 1'b0;
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (reset_n)
        begin
            ack_count   <= 0;
            fill_active <= 1'b0;
            fill_phase  <= 0;
            fill_base   <= '0;
            shift_num   <= 0;
            win_idx     <= 0;
            prev_kick   <= 1'b0;
            prev_done   <= 1'b0;
            done_count  <= 0;
        end
        else
        begin
            prev_kick <= pe.pe_kick;
            prev_done <= fr_done;
            if (fr_done)
                done_count <= done_count + 1;
            if (fr_next_angle_ack)
            begin
                ack_count <= ack_count + 1;
                if (ack_count < NUM_ANGLES)
                begin
                    fill_active <= 1'b1;
                    fill_phase  <= 0;
                    fill_base   <= addr_t'(base_for(angle_list[ack_count]));
                end
            end
            else if (fill_active)
            begin
                fill_phase <= fill_phase + 1;
                if (fill_phase == FILL_LAG + LINE_LEN - 1)
                    fill_active <= 1'b0;
            end
            // a falling pe_kick closes the shift of one angle
            if (pe.pe_kick)
                win_idx <= win_idx + 1;
            else if (prev_kick)
            begin
                win_idx   <= 0;
                shift_num <= shift_num + 1;
            end
        end
    end

    always_comb
    begin
        cur_angle       = (shift_num < NUM_ANGLES) ? angle_list[shift_num] : 8'd0;
        tap_pos         = base_for(cur_angle) + win_idx * stride_for(cur_angle);
        shifts_complete = shift_num + int'(prev_kick && !pe.pe_kick);
        exp_fill_addr   = fill_base + addr_t'(fill_phase - FILL_LAG);
        for (int i = 0; i < PARTITIONS; i++)
            exp_taps[i] = sample_t'((tap_pos + i) * 3 + int'(cur_angle));
    end

    assert property (@(posedge clk) disable iff (reset_n) first_cycle |-> fr_next_angle)
        else value_error(1, "fr_next_angle", 1, $sampled(fr_next_angle));
    assert property (@(posedge clk) disable iff (reset_n) first_cycle |-> !pe.pe_kick)
        else value_error(1, "pe.pe_kick", 0, $sampled(pe.pe_kick));
    assert property (@(posedge clk) disable iff (reset_n) first_cycle |-> !fr_done)
        else value_error(1, "fr_done", 0, $sampled(fr_done));

    assert property (@(posedge clk) disable iff (reset_n)
        fill_active && fill_phase >= FILL_LAG |-> fr0_s_val == exp_fill_addr)
        else value_error(2, "fr0_s_val", $sampled(exp_fill_addr), $sampled(fr0_s_val));

    // side 1 address holds while side 0 is walked
    assert property (@(posedge clk) disable iff (reset_n)
        fill_active && fill_phase > FILL_LAG |-> $stable(fr1_s_val))
        else event_error(2, "fr1_s_val moved while side 0 was being filled");

    assert property (@(posedge clk) disable iff (reset_n) pe.pe_kick |-> pe.taps == exp_taps)
        else value_error(3, "pe.taps", $sampled(exp_taps), $sampled(pe.taps));

    assert property (@(posedge clk) disable iff (reset_n)
        prev_kick && !pe.pe_kick |-> win_idx == windows_for(cur_angle))
        else value_error(4, "pe_kick count", windows_for($sampled(cur_angle)),
                         $sampled(win_idx));

    assert property (@(posedge clk) disable iff (reset_n)
        pe.pe_kick |-> pe.pe_scan_mode == mode_for(cur_angle))
        else value_error(5, "pe.pe_scan_mode", mode_for(cur_angle), $sampled(pe.pe_scan_mode));
    assert property (@(posedge clk) disable iff (reset_n)
        pe.pe_kick |-> pe.pe_scan_direction == dir_for(cur_angle))
        else value_error(5, "pe.pe_scan_direction", dir_for(cur_angle),
                         $sampled(pe.pe_scan_direction));

    assert property (@(posedge clk) disable iff (reset_n) pe.pe_kick |-> shift_num < NUM_ANGLES)
        else event_error(6, "pe_kick seen after every angle was already shifted");
    assert property (@(posedge clk) disable iff (reset_n) fr_done |-> done_count == 0)
        else event_error(6, "fr_done pulsed more than once");
    assert property (@(posedge clk) disable iff (reset_n)
        fr_done |-> shifts_complete == NUM_ANGLES)
        else value_error(6, "shifts completed at fr_done", NUM_ANGLES, $sampled(shifts_complete));
    assert property (@(posedge clk) disable iff (reset_n) prev_done |-> fr_next_angle)
        else value_error(6, "fr_next_angle", 1, $sampled(fr_next_angle));

    // watchdog sized from the number of angles
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: fr_done not seen within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int passed;
        int failed;
        reset_n           = 1'b1;
        fr0               = '0;
        fr1               = '0;
        fr_next_angle_ack = 1'b0;
        first_cycle       = 1'b0;
        lfsr              = 16'd62134;
        for (int t = 1; t <= 6; t++)
            err_count[t] = 0;
        build_angle_list();

        repeat (RESET_CYCLES) @(negedge clk);
        reset_n     = 1'b0;
        first_cycle = 1'b1;
        @(negedge clk);
        first_cycle = 1'b0;
        report_test(1, "reset state");

        serve_requests();
        while (done_count == 0)
            @(negedge clk);
        repeat (4) @(negedge clk);

        assert (shift_num == NUM_ANGLES)
            else value_error(6, "angles shifted", NUM_ANGLES, shift_num);
        assert (done_count == 1)
            else value_error(6, "fr_done pulses", 1, done_count);

        report_test(2, "fill addressing");
        report_test(3, "tap contents");
        report_test(4, "window count");
        report_test(5, "scan decode");
        report_test(6, "swap order and completion");

        passed = 0;
        failed = 0;
        for (int t = 1; t <= 6; t++)
        begin
            if (err_count[t] == 0)
                passed++;
            else
                failed++;
        end
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
logic/nabp_pkg.sv
logic/shifter_lut.sv
logic/mapper_lut.sv
logic/processing_swappable.sv
logic/processing_swap_control.sv
bench/tb_processing.sv
